// ==== common/lstm_fixed_pkg.sv ====
package lstm_fixed_pkg;

        localparam int WIDTH    = 32;
        localparam int FRAC     = 24;
        localparam int LR_SHIFT = 3;

        // Q8.24 word and the full product of two words
        typedef logic signed [WIDTH-1:0]   fix_t;
        typedef logic signed [2*WIDTH-1:0] fix_wide_t;

        // One value per gate
        typedef struct packed {
                fix_t a;
                fix_t i;
                fix_t f;
                fix_t o;
        } gate_vec_t;

        // Learning rate 0.125
        function automatic fix_t lr_scale(fix_t v);
                return v >>> LR_SHIFT;
        endfunction

        function automatic gate_vec_t vec_lr_scale(gate_vec_t v);
                gate_vec_t r;
                r.a = lr_scale(v.a);
                r.i = lr_scale(v.i);
                r.f = lr_scale(v.f);
                r.o = lr_scale(v.o);
                return r;
        endfunction

        // Per-gate add and subtract, both wrap in WIDTH
        function automatic gate_vec_t vec_add(gate_vec_t x, gate_vec_t y);
                gate_vec_t r;
                r.a = x.a + y.a;
                r.i = x.i + y.i;
                r.f = x.f + y.f;
                r.o = x.o + y.o;
                return r;
        endfunction

        function automatic gate_vec_t vec_sub(gate_vec_t x, gate_vec_t y);
                gate_vec_t r;
                r.a = x.a - y.a;
                r.i = x.i - y.i;
                r.f = x.f - y.f;
                r.o = x.o - y.o;
                return r;
        endfunction

endpackage

// ==== common/lstm_mem_map_pkg.sv ====
package lstm_mem_map_pkg;

        localparam int N_INPUT = 53;
        localparam int N_CELL  = 53;
        localparam int W_DEPTH = N_INPUT * N_CELL;
        localparam int D_DEPTH = 371;

        localparam int X_AW = $clog2(N_INPUT);
        localparam int W_AW = $clog2(W_DEPTH);
        localparam int B_AW = $clog2(N_CELL);
        localparam int D_AW = $clog2(D_DEPTH);

        // Weight memory has the widest address
        localparam int LOAD_AW = W_AW;

        typedef logic [X_AW-1:0]    x_addr_t;
        typedef logic [W_AW-1:0]    w_addr_t;
        typedef logic [B_AW-1:0]    b_addr_t;
        typedef logic [D_AW-1:0]    d_addr_t;
        typedef logic [LOAD_AW-1:0] load_addr_t;

        typedef enum logic [1:0] {
                SEL_X,
                SEL_W,
                SEL_B,
                SEL_D
        } mem_sel_e;

        // One step from the controller
        typedef struct packed {
                logic    valid;
                logic    update;
                logic    first;
                x_addr_t x_addr;
                w_addr_t w_addr;
                b_addr_t b_addr;
                d_addr_t d_addr;
        } step_t;

        // Host preload word
        typedef struct packed {
                logic                      valid;
                mem_sel_e                  sel;
                load_addr_t                addr;
                lstm_fixed_pkg::gate_vec_t data;
        } load_t;

endpackage

// ==== rtl/param_mem.sv ====
`timescale 1ns/1ps

module param_mem #(
        parameter type T     = logic [31:0],
        parameter int  DEPTH = 64
) (
        input  logic                     i_clk,
        input  logic                     i_wr_en,
        input  logic [$clog2(DEPTH)-1:0] i_wr_addr,
        input  T                         i_wr_data,
        input  logic [$clog2(DEPTH)-1:0] i_rd_addr,
        output T                         o_rd_data
);

        T mem [DEPTH];

        always_ff @(posedge i_clk) begin
                if (i_wr_en) begin
                        mem[i_wr_addr] <= i_wr_data;
                end
        end

        // Write-first on a same-address read
        always_ff @(posedge i_clk) begin
                if (i_wr_en && (i_wr_addr == i_rd_addr)) begin
                        o_rd_data <= i_wr_data;
                end else begin
                        o_rd_data <= mem[i_rd_addr];
                end
        end

endmodule

// ==== gate_mac/gate_mac.sv ====
`timescale 1ns/1ps

module gate_mac (
        input  logic                      i_clk,
        input  logic                      i_rst,
        input  logic                      i_valid,
        input  logic                      i_update,
        input  logic                      i_first,
        input  lstm_fixed_pkg::fix_t      i_x,
        input  lstm_fixed_pkg::gate_vec_t i_w,
        input  lstm_fixed_pkg::gate_vec_t i_b,
        input  lstm_fixed_pkg::gate_vec_t i_d,
        output lstm_fixed_pkg::gate_vec_t o_prod,
        output lstm_fixed_pkg::gate_vec_t o_z,
        output logic                      o_z_valid
);

        import lstm_fixed_pkg::*;

        // Full product, scaled back to Q8.24
        function automatic fix_t fix_mul(fix_t x, fix_t y);
                fix_wide_t p;
                p = fix_wide_t'(x) * fix_wide_t'(y);
                return fix_t'(p >>> FRAC);
        endfunction

        fix_t      mul_x;
        gate_vec_t mul_c;
        gate_vec_t acc_q;
        gate_vec_t acc_base;
        logic      fwd_step;

        ////////////////////////////////////////
        // Operand select and multipliers
        ////////////////////////////////////////

        // Update: (x * 0.125) * dgate
        assign mul_x = i_update ? lr_scale(i_x) : i_x;
        assign mul_c = i_update ? i_d : i_w;

        always_comb begin
                o_prod.a = fix_mul(mul_x, mul_c.a);
                o_prod.i = fix_mul(mul_x, mul_c.i);
                o_prod.f = fix_mul(mul_x, mul_c.f);
                o_prod.o = fix_mul(mul_x, mul_c.o);
        end

        ////////////////////////////////////////
        // Forward accumulator
        ////////////////////////////////////////

        assign fwd_step = i_valid && !i_update;

        // First step of a sequence starts from the bias
        assign acc_base = i_first ? i_b : acc_q;

        always_ff @(posedge i_clk) begin
                if (i_rst) begin
                        acc_q     <= '0;
                        o_z_valid <= 1'b0;
                end else begin
                        o_z_valid <= fwd_step;
                        if (fwd_step) begin
                                acc_q <= vec_add(acc_base, o_prod);
                        end
                end
        end

        assign o_z = acc_q;

endmodule

// ==== rtl/param_update.sv ====
`timescale 1ns/1ps

module param_update (
        input  logic                       i_clk,
        input  logic                       i_rst,
        input  logic                       i_valid,
        input  logic                       i_update,
        input  lstm_fixed_pkg::gate_vec_t  i_w,
        input  lstm_fixed_pkg::gate_vec_t  i_b,
        input  lstm_fixed_pkg::gate_vec_t  i_d,
        input  lstm_fixed_pkg::gate_vec_t  i_prod,
        input  lstm_mem_map_pkg::w_addr_t  i_w_addr,
        input  lstm_mem_map_pkg::b_addr_t  i_b_addr,
        output logic                       o_wr_en,
        output lstm_mem_map_pkg::w_addr_t  o_w_addr,
        output lstm_mem_map_pkg::b_addr_t  o_b_addr,
        output lstm_fixed_pkg::gate_vec_t  o_new_w,
        output lstm_fixed_pkg::gate_vec_t  o_new_b
);

        import lstm_fixed_pkg::*;
        import lstm_mem_map_pkg::*;

        gate_vec_t new_w;
        gate_vec_t new_b;

        // w - lr*x*d and b - lr*d
        assign new_w = vec_sub(i_w, i_prod);
        assign new_b = vec_sub(i_b, vec_lr_scale(i_d));

        always_ff @(posedge i_clk) begin
                if (i_rst) begin
                        o_wr_en <= 1'b0;
                end else begin
                        o_wr_en <= i_valid && i_update;
                end
        end

        // Write-back payload
        always_ff @(posedge i_clk) begin
                o_w_addr <= i_w_addr;
                o_b_addr <= i_b_addr;
                o_new_w  <= new_w;
                o_new_b  <= new_b;
        end

endmodule

// ==== rtl/lstm_param_engine.sv ====
`timescale 1ns/1ps

module lstm_param_engine (
        input  logic                       i_clk,
        input  logic                       i_rst,
        input  lstm_mem_map_pkg::load_t    i_load,
        input  lstm_mem_map_pkg::step_t    i_step,
        output lstm_fixed_pkg::gate_vec_t  o_z,
        output logic                       o_z_valid
);

        import lstm_fixed_pkg::*;
        import lstm_mem_map_pkg::*;

        logic      ld_x;
        logic      ld_w;
        logic      ld_b;
        logic      ld_d;

        logic      w_wr_en;
        w_addr_t   w_wr_addr;
        gate_vec_t w_wr_data;
        logic      b_wr_en;
        b_addr_t   b_wr_addr;
        gate_vec_t b_wr_data;

        fix_t      x_rd;
        gate_vec_t w_rd;
        gate_vec_t b_rd;
        gate_vec_t d_rd;

        logic      s1_valid;
        logic      s1_update;
        logic      s1_first;
        w_addr_t   s1_w_addr;
        b_addr_t   s1_b_addr;

        gate_vec_t prod;
        logic      upd_wr_en;
        w_addr_t   upd_w_addr;
        b_addr_t   upd_b_addr;
        gate_vec_t upd_new_w;
        gate_vec_t upd_new_b;

        ////////////////////////////////////////
        // Load decode
        ////////////////////////////////////////

        assign ld_x = i_load.valid && (i_load.sel == SEL_X);
        assign ld_w = i_load.valid && (i_load.sel == SEL_W);
        assign ld_b = i_load.valid && (i_load.sel == SEL_B);
        assign ld_d = i_load.valid && (i_load.sel == SEL_D);

        // Host load wins over update write-back
        assign w_wr_en   = ld_w || upd_wr_en;
        assign w_wr_addr = ld_w ? w_addr_t'(i_load.addr) : upd_w_addr;
        assign w_wr_data = ld_w ? i_load.data : upd_new_w;

        assign b_wr_en   = ld_b || upd_wr_en;
        assign b_wr_addr = ld_b ? b_addr_t'(i_load.addr) : upd_b_addr;
        assign b_wr_data = ld_b ? i_load.data : upd_new_b;

        ////////////////////////////////////////
        // Parameter memories
        ////////////////////////////////////////

        param_mem #(.T(fix_t), .DEPTH(N_INPUT)) u_mem_x (
                .i_clk     (i_clk),
                .i_wr_en   (ld_x),
                .i_wr_addr (x_addr_t'(i_load.addr)),
                .i_wr_data (i_load.data.a),
                .i_rd_addr (i_step.x_addr),
                .o_rd_data (x_rd)
        );

        param_mem #(.T(gate_vec_t), .DEPTH(W_DEPTH)) u_mem_w (
                .i_clk     (i_clk),
                .i_wr_en   (w_wr_en),
                .i_wr_addr (w_wr_addr),
                .i_wr_data (w_wr_data),
                .i_rd_addr (i_step.w_addr),
                .o_rd_data (w_rd)
        );

        param_mem #(.T(gate_vec_t), .DEPTH(N_CELL)) u_mem_b (
                .i_clk     (i_clk),
                .i_wr_en   (b_wr_en),
                .i_wr_addr (b_wr_addr),
                .i_wr_data (b_wr_data),
                .i_rd_addr (i_step.b_addr),
                .o_rd_data (b_rd)
        );

        // Gradients come from the host only
        param_mem #(.T(gate_vec_t), .DEPTH(D_DEPTH)) u_mem_d (
                .i_clk     (i_clk),
                .i_wr_en   (ld_d),
                .i_wr_addr (d_addr_t'(i_load.addr)),
                .i_wr_data (i_load.data),
                .i_rd_addr (i_step.d_addr),
                .o_rd_data (d_rd)
        );

        ////////////////////////////////////////
        // Stage 1, aligned with read data
        ////////////////////////////////////////

        always_ff @(posedge i_clk) begin
                if (i_rst) begin
                        s1_valid <= 1'b0;
                end else begin
                        s1_valid <= i_step.valid;
                end
        end

        always_ff @(posedge i_clk) begin
                s1_update <= i_step.update;
                s1_first  <= i_step.first;
                s1_w_addr <= i_step.w_addr;
                s1_b_addr <= i_step.b_addr;
        end

        gate_mac u_gate_mac (
                .i_clk     (i_clk),
                .i_rst     (i_rst),
                .i_valid   (s1_valid),
                .i_update  (s1_update),
                .i_first   (s1_first),
                .i_x       (x_rd),
                .i_w       (w_rd),
                .i_b       (b_rd),
                .i_d       (d_rd),
                .o_prod    (prod),
                .o_z       (o_z),
                .o_z_valid (o_z_valid)
        );

        param_update u_param_update (
                .i_clk    (i_clk),
                .i_rst    (i_rst),
                .i_valid  (s1_valid),
                .i_update (s1_update),
                .i_w      (w_rd),
                .i_b      (b_rd),
                .i_d      (d_rd),
                .i_prod   (prod),
                .i_w_addr (s1_w_addr),
                .i_b_addr (s1_b_addr),
                .o_wr_en  (upd_wr_en),
                .o_w_addr (upd_w_addr),
                .o_b_addr (upd_b_addr),
                .o_new_w  (upd_new_w),
                .o_new_b  (upd_new_b)
        );

endmodule

// ==== tests/tb_lstm_param_engine.sv ====
`timescale 1ns/1ps

module tb_lstm_param_engine;

        import lstm_fixed_pkg::*;
        import lstm_mem_map_pkg::*;

        localparam int TIMEOUT = 50;

        logic      clk;
        logic      rst;
        load_t     load;
        step_t     step;
        gate_vec_t z;
        logic      z_valid;

        logic [31:0] lcg_state = 32'hf49c08da;

        // Reference copies of the memories
        fix_t      x_ref [N_INPUT];
        gate_vec_t w_ref [W_DEPTH];
        gate_vec_t b_ref [N_CELL];
        gate_vec_t d_ref [D_DEPTH];

        step_t     step_q [$];
        gate_vec_t exp_q [$];

        lstm_param_engine uut (
                .i_clk     (clk),
                .i_rst     (rst),
                .i_load    (load),
                .i_step    (step),
                .o_z       (z),
                .o_z_valid (z_valid)
        );

        initial begin
                clk = 1'b0;
                forever #2 clk = ~clk;
        end

        function automatic logic [31:0] lcg_next();
                lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
                return lcg_state;
        endfunction

        // Upper LCG bits within plus or minus 1.0
        function automatic fix_t rand_fix();
                logic [31:0] r;
                r = lcg_next();
                return fix_t'({{7{r[31]}}, r[31:7]});
        endfunction

        function automatic gate_vec_t rand_vec();
                gate_vec_t r;
                r.a = rand_fix();
                r.i = rand_fix();
                r.f = rand_fix();
                r.o = rand_fix();
                return r;
        endfunction

        ////////////////////////////////////////
        // Reference arithmetic
        ////////////////////////////////////////

        function automatic fix_t scaled_mul(fix_t a, fix_t b);
                longint p;
                p = longint'(a) * longint'(b);
                return fix_t'(p >>> FRAC);
        endfunction

        function automatic gate_vec_t mac_gates(gate_vec_t base, fix_t x, gate_vec_t w);
                gate_vec_t r;
                r.a = base.a + scaled_mul(x, w.a);
                r.i = base.i + scaled_mul(x, w.i);
                r.f = base.f + scaled_mul(x, w.f);
                r.o = base.o + scaled_mul(x, w.o);
                return r;
        endfunction

        function automatic gate_vec_t upd_weight(gate_vec_t w, fix_t x, gate_vec_t d);
                gate_vec_t r;
                fix_t      xs;
                xs  = x >>> LR_SHIFT;
                r.a = w.a - scaled_mul(xs, d.a);
                r.i = w.i - scaled_mul(xs, d.i);
                r.f = w.f - scaled_mul(xs, d.f);
                r.o = w.o - scaled_mul(xs, d.o);
                return r;
        endfunction

        function automatic gate_vec_t upd_bias(gate_vec_t b, gate_vec_t d);
                gate_vec_t r;
                r.a = b.a - (d.a >>> LR_SHIFT);
                r.i = b.i - (d.i >>> LR_SHIFT);
                r.f = b.f - (d.f >>> LR_SHIFT);
                r.o = b.o - (d.o >>> LR_SHIFT);
                return r;
        endfunction

        function automatic step_t make_step(logic upd, logic first, int xa, int wa, int ba,
                                            int da);
                step_t s;
                s.valid  = 1'b1;
                s.update = upd;
                s.first  = first;
                s.x_addr = x_addr_t'(xa);
                s.w_addr = w_addr_t'(wa);
                s.b_addr = b_addr_t'(ba);
                s.d_addr = d_addr_t'(da);
                return s;
        endfunction

        ////////////////////////////////////////
        // Driving and checking
        ////////////////////////////////////////

        task automatic stop_on_error();
                $display("SOME TESTS FAILED");
                $fatal(1);
        endtask

        task automatic check_vec(input string name, input gate_vec_t got, input gate_vec_t exp);
                if (got !== exp) begin
                        $display("FAILED %s: got %h expected %h", name, got, exp);
                        stop_on_error();
                end
        endtask

        task automatic check_flag(input string name, input logic got, input logic exp);
                if (got !== exp) begin
                        $display("FAILED %s: got %h expected %h", name, got, exp);
                        stop_on_error();
                end
        endtask

        task automatic load_word(input mem_sel_e sel, input int addr, input gate_vec_t data);
                @(posedge clk);
                load.valid <= 1'b1;
                load.sel   <= sel;
                load.addr  <= load_addr_t'(addr);
                load.data  <= data;
                case (sel)
                        SEL_X:   x_ref[addr] = data.a;
                        SEL_W:   w_ref[addr] = data;
                        SEL_B:   b_ref[addr] = data;
                        default: d_ref[addr] = data;
                endcase
                @(posedge clk);
                load.valid <= 1'b0;
        endtask

        task automatic wait_z_valid(output int cycles);
                cycles = 0;
                do begin
                        @(negedge clk);
                        cycles++;
                        if (cycles > TIMEOUT) begin
                                $display("Timeout while waiting for o_z_valid to go high");
                                stop_on_error();
                        end
                end while (z_valid !== 1'b1);
        endtask

        // Steps go back to back and each pulse lands two cycles after its step
        task automatic run_queue();
                step_t     s;
                gate_vec_t acc;
                gate_vec_t w_new;
                logic      expect_pulse;
                int        n;
                n   = step_q.size();
                acc = '0;
                foreach (step_q[m]) begin
                        s = step_q[m];
                        if (s.valid && s.update) begin
                                w_new = upd_weight(w_ref[s.w_addr], x_ref[s.x_addr],
                                                   d_ref[s.d_addr]);
                                b_ref[s.b_addr] = upd_bias(b_ref[s.b_addr], d_ref[s.d_addr]);
                                w_ref[s.w_addr] = w_new;
                        end else if (s.valid) begin
                                acc = mac_gates(s.first ? b_ref[s.b_addr] : acc,
                                                x_ref[s.x_addr], w_ref[s.w_addr]);
                                exp_q.push_back(acc);
                        end
                end
                for (int m = 0; m < n + 3; m++) begin
                        @(posedge clk);
                        if (m < n) begin
                                step <= step_q[m];
                        end else begin
                                step <= '0;
                        end
                        @(negedge clk);
                        expect_pulse = 1'b0;
                        if (m >= 2 && m < n + 2) begin
                                expect_pulse = step_q[m-2].valid && !step_q[m-2].update;
                        end
                        check_flag("o_z_valid", z_valid, expect_pulse);
                        if (expect_pulse) begin
                                check_vec("o_z", z, exp_q.pop_front());
                        end
                end
                step_q.delete();
        endtask

        ////////////////////////////////////////
        // Tests
        ////////////////////////////////////////

        task automatic test_reset_idle();
                repeat (6) begin
                        @(negedge clk);
                        check_flag("o_z_valid", z_valid, 1'b0);
                end
        endtask

        task automatic test_single_forward();
                gate_vec_t expv;
                int        cycles;
                load_word(SEL_X, 3, rand_vec());
                load_word(SEL_W, 100, rand_vec());
                load_word(SEL_B, 7, rand_vec());
                expv = mac_gates(b_ref[7], x_ref[3], w_ref[100]);
                @(posedge clk);
                step <= make_step(1'b0, 1'b1, 3, 100, 7, 0);
                @(posedge clk);
                step <= '0;
                wait_z_valid(cycles);
                if (cycles != 2) begin
                        $display("o_z_valid rose %0d cycles after the step instead of 2", cycles);
                        stop_on_error();
                end
                check_vec("o_z", z, expv);
                @(negedge clk);
                check_flag("o_z_valid", z_valid, 1'b0);
        endtask

        task automatic test_accumulate();
                for (int n = 0; n < 8; n++) begin
                        load_word(SEL_X, n, rand_vec());
                        load_word(SEL_W, 200 + n, rand_vec());
                        step_q.push_back(make_step(1'b0, n == 0, n, 200 + n, 10, 0));
                end
                load_word(SEL_B, 10, rand_vec());
                run_queue();
                // New sequence from its own bias
                for (int n = 0; n < 3; n++) begin
                        load_word(SEL_X, 20 + n, rand_vec());
                        load_word(SEL_W, 300 + n, rand_vec());
                        step_q.push_back(make_step(1'b0, n == 0, 20 + n, 300 + n, 11, 0));
                end
                load_word(SEL_B, 11, rand_vec());
                run_queue();
        endtask

        task automatic test_update();
                gate_vec_t one;
                one   = '0;
                one.a = 32'h01000000;
                load_word(SEL_X, 30, rand_vec());
                load_word(SEL_X, 31, one);
                load_word(SEL_W, 500, rand_vec());
                load_word(SEL_B, 20, rand_vec());
                load_word(SEL_D, 100, rand_vec());
                step_q.push_back(make_step(1'b1, 1'b0, 30, 500, 20, 100));
                step_q.push_back(step_t'(0));
                // x = 1.0 reads back w_new + b_new on the write cycle itself
                step_q.push_back(make_step(1'b0, 1'b1, 31, 500, 20, 0));
                run_queue();
        endtask

        task automatic test_update_side_effect();
                for (int n = 0; n < 3; n++) begin
                        load_word(SEL_X, 40 + n, rand_vec());
                        load_word(SEL_W, 800 + n, rand_vec());
                end
                load_word(SEL_B, 30, rand_vec());
                step_q.push_back(make_step(1'b0, 1'b1, 40, 800, 30, 0));
                step_q.push_back(make_step(1'b0, 1'b0, 41, 801, 30, 0));
                step_q.push_back(make_step(1'b1, 1'b0, 30, 500, 20, 100));
                step_q.push_back(make_step(1'b0, 1'b0, 42, 802, 30, 0));
                run_queue();
        endtask

        initial begin
                rst  = 1'b1;
                load = '0;
                step = '0;
                repeat (3) @(posedge clk);
                rst <= 1'b0;
                test_reset_idle();
                test_single_forward();
                test_accumulate();
                test_update();
                test_update_side_effect();
                $display("ALL TESTS PASSED");
                $finish;
        end

endmodule

// ==== sources.f ====
common/lstm_fixed_pkg.sv
common/lstm_mem_map_pkg.sv
rtl/param_mem.sv
gate_mac/gate_mac.sv
rtl/param_update.sv
rtl/lstm_param_engine.sv
tests/tb_lstm_param_engine.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" \
        && verilator --binary --timing -Wno-fatal --top-module tb_lstm_param_engine \
                -f sources.f -o tb_sim \
        && ./obj_dir/tb_sim | tee /dev/stderr | grep -F -q "ALL TESTS PASSED" \
        && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
